//--- rtl/dcache_pkg.sv
package dcache_pkg;

    // geometry
    localparam int INDEX_W    = 6;
    localparam int OFFSET_W   = 6;
    localparam int TAG_W      = 32 - INDEX_W - OFFSET_W;
    localparam int SETS       = 1 << INDEX_W;
    localparam int WORDS      = 16;
    localparam int LINE_BYTES = 64;
    localparam int LINE_W     = 512;

    // store masks, loads reuse them as the access size
    localparam logic [3:0] STRB_BYTE = 4'b0001;
    localparam logic [3:0] STRB_HALF = 4'b0011;
    localparam logic [3:0] STRB_WORD = 4'b1111;

    localparam logic [6:0] EXP_ALE = 7'h09;    // address not aligned

    // main fsm encoding
    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_LOOKUP    = 3'd1;
    localparam logic [2:0] ST_WRITEBACK = 3'd2;
    localparam logic [2:0] ST_READ      = 3'd3;
    localparam logic [2:0] ST_REFILL    = 3'd4;
    localparam logic [2:0] ST_RESPOND   = 3'd5;

    // one cache line, word view for loads, byte view for stores
    typedef union packed {
        logic [WORDS-1:0][31:0]     w;
        logic [LINE_BYTES-1:0][7:0] b;
    } line_t;

    typedef logic way_t;

endpackage

//--- rtl/dcache_ifs.sv
`timescale 1ns/1ps

// tag lookup and metadata update between the FSM and the metadata store
interface meta_if import dcache_pkg::*; ();
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic               fill_we;      // write tag, set valid
    way_t               fill_way;     // target way for fill, dirty and lru writes
    logic               dirty_we;
    logic               dirty_val;
    logic               lru_we;
    logic               hit;
    way_t               hit_way;
    way_t               victim_way;
    logic               victim_dirty;
    logic [TAG_W-1:0]   victim_tag;

    modport master (
        output index, tag, fill_we, fill_way, dirty_we, dirty_val, lru_we,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport slave (
        input  index, tag, fill_we, fill_way, dirty_we, dirty_val, lru_we,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );
endinterface

// victim writeback request
interface wr_if import dcache_pkg::*; ();
    logic        start;   // one cycle pulse
    logic [31:0] addr;
    line_t       line;
    logic        done;    // held until the next start

    modport master (
        output start, addr, line,
        input  done
    );

    modport slave (
        input  start, addr, line,
        output done
    );
endinterface

//--- rtl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import dcache_pkg::*; (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [31:0]                i_addr,
    input  logic                       i_rvalid,
    input  logic                       i_wvalid,
    input  logic [31:0]                i_wdata,
    input  logic [3:0]                 i_wstrb,
    input  logic                       i_signed,
    meta_if.master                     meta,
    wr_if.master                       wr,
    output logic                       o_rready,
    output logic                       o_wready,
    output logic                       o_idle,
    output logic [6:0]                 o_exception,
    output logic [31:0]                o_badv,
    output logic                       o_mem_rvalid,
    input  logic                       i_mem_rready,
    output logic [31:0]                o_mem_raddr,
    input  logic                       i_mem_wvalid,
    input  logic                       i_ale,
    input  line_t                      i_rline0,
    input  line_t                      i_rline1,
    input  logic [LINE_BYTES-1:0]      i_store_be,
    output line_t                      o_sel_line,
    output logic [INDEX_W-1:0]         o_data_index,
    output logic [1:0][LINE_BYTES-1:0] o_data_we,
    output logic                       o_data_wsel,
    output logic [31:0]                o_req_addr,
    output logic [31:0]                o_req_wdata,
    output logic [3:0]                 o_req_wstrb,
    output logic                       o_req_signed,
    output logic                       o_req_store
);
    logic [2:0]         state;
    logic [2:0]         state_nx;
    logic               accept;
    logic               lookup;
    logic               hit_upd;     // hit without exception
    logic               miss;
    logic               refill;
    logic               respond;
    logic               fill_hs;     // read handshake
    logic [INDEX_W-1:0] req_index;
    logic [INDEX_W-1:0] index;
    way_t               vway_q;      // way chosen for the refill
    way_t               rway;

    assign accept    = (state == ST_IDLE) && (i_rvalid || i_wvalid);
    assign lookup    = state == ST_LOOKUP;
    assign hit_upd   = lookup && meta.hit && !i_ale;
    assign miss      = lookup && !meta.hit && !i_ale;
    assign refill    = state == ST_REFILL;
    assign fill_hs   = (state == ST_READ) && i_mem_rready;
    assign req_index = o_req_addr[OFFSET_W +: INDEX_W];

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            o_req_addr   <= i_addr;
            o_req_wdata  <= i_wdata;
            o_req_wstrb  <= i_wstrb;
            o_req_signed <= i_signed;
            o_req_store  <= i_wvalid;
        end
        if (lookup) vway_q <= meta.victim_way;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            ST_IDLE:      if (accept) state_nx = ST_LOOKUP;
            ST_LOOKUP: begin
                if (i_ale || meta.hit) state_nx = ST_IDLE;
                else if (meta.victim_dirty) state_nx = ST_WRITEBACK;
                else state_nx = ST_READ;
            end
            ST_WRITEBACK: if (wr.done) state_nx = ST_READ;
            ST_READ:      if (i_mem_rready) state_nx = ST_REFILL;
            ST_REFILL:    state_nx = ST_RESPOND;
            default:      state_nx = ST_IDLE;
        endcase
    end

    // arrays are addressed from the input while idle so the read lands in LOOKUP
    assign index        = (state == ST_IDLE) ? i_addr[OFFSET_W +: INDEX_W] : req_index;
    assign o_data_index = index;

    // hit way on a hit, victim on a miss, refilled way afterwards
    assign rway       = lookup ? (meta.hit ? meta.hit_way : meta.victim_way) : vway_q;
    assign o_sel_line = rway ? i_rline1 : i_rline0;

    assign meta.index     = index;
    assign meta.tag       = o_req_addr[31 -: TAG_W];
    assign meta.fill_we   = refill;
    assign meta.fill_way  = refill ? vway_q : meta.hit_way;
    assign meta.dirty_we  = refill || (hit_upd && o_req_store);
    assign meta.dirty_val = o_req_store;   // refill of a load leaves the line clean
    assign meta.lru_we    = refill || hit_upd;

    // line data goes in on the handshake, tags follow in REFILL
    always_comb begin
        o_data_we = '0;
        if (hit_upd && o_req_store) o_data_we[meta.hit_way] = i_store_be;
        else if (fill_hs) o_data_we[vway_q] = '1;
    end
    assign o_data_wsel = state == ST_READ;

    assign wr.start = miss && meta.victim_dirty;
    assign wr.addr  = {meta.victim_tag, req_index, {OFFSET_W{1'b0}}};
    assign wr.line  = o_sel_line;

    assign o_mem_rvalid = state == ST_READ;
    assign o_mem_raddr  = {o_req_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};

    assign respond     = (lookup && (i_ale || meta.hit)) || (state == ST_RESPOND);
    assign o_rready    = respond && !o_req_store;
    assign o_wready    = respond && o_req_store;
    assign o_idle      = state == ST_IDLE;
    assign o_exception = (lookup && i_ale) ? EXP_ALE : 7'd0;
    assign o_badv      = (lookup && i_ale) ? o_req_addr : 32'd0;

    // writeback must finish before the line is requested
    a_one_mem_channel: assert property (@(posedge clk) disable iff (!rstn)
        !(o_mem_rvalid && i_mem_wvalid))
        else $error("memory read and write requested in the same cycle");

endmodule

//--- rtl/meta_store.sv
`timescale 1ns/1ps

module meta_store import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    meta_if.slave  meta
);
    logic [TAG_W-1:0] tags [2][SETS];
    logic [SETS-1:0]  valid [2];
    logic [SETS-1:0]  dirty [2];
    logic [SETS-1:0]  lru;            // most recently used way per set
    logic [TAG_W-1:0] rd_tag [2];
    logic [1:0]       rd_valid;
    logic [1:0]       rd_dirty;
    logic             rd_lru;
    logic [1:0]       hit_vec;
    way_t             victim;

    // tag arrays, read before write
    always_ff @(posedge clk) begin
        if (meta.fill_we) tags[meta.fill_way][meta.index] <= meta.tag;
        rd_tag[0] <= tags[0][meta.index];
        rd_tag[1] <= tags[1][meta.index];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < 2; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
            lru      <= '0;
            rd_valid <= '0;
            rd_dirty <= '0;
            rd_lru   <= 1'b0;
        end else begin
            if (meta.fill_we) valid[meta.fill_way][meta.index] <= 1'b1;
            if (meta.dirty_we) dirty[meta.fill_way][meta.index] <= meta.dirty_val;
            if (meta.lru_we) lru[meta.index] <= meta.fill_way;
            rd_valid <= {valid[1][meta.index], valid[0][meta.index]};
            rd_dirty <= {dirty[1][meta.index], dirty[0][meta.index]};
            rd_lru   <= lru[meta.index];
        end
    end

    assign hit_vec[0] = rd_valid[0] && (rd_tag[0] == meta.tag);
    assign hit_vec[1] = rd_valid[1] && (rd_tag[1] == meta.tag);

    // an empty way first, else the one not used last
    always_comb begin
        if (!rd_valid[0]) victim = 1'b0;
        else if (!rd_valid[1]) victim = 1'b1;
        else victim = !rd_lru;
    end

    assign meta.hit          = |hit_vec;
    assign meta.hit_way      = hit_vec[1];
    assign meta.victim_way   = victim;
    assign meta.victim_dirty = rd_valid[victim] && rd_dirty[victim];
    assign meta.victim_tag   = rd_tag[victim];

    // a tag is only ever filled into one way of a set
    a_single_hit: assert property (@(posedge clk) disable iff (!rstn) !(&hit_vec))
        else $error("tag present in both ways of a set");

endmodule

//--- rtl/data_store.sv
`timescale 1ns/1ps

module data_store import dcache_pkg::*; (
    input  logic                       clk,
    input  logic [INDEX_W-1:0]         i_index,
    input  logic [1:0][LINE_BYTES-1:0] i_we,      // byte enables per way
    input  line_t                      i_wline,
    output line_t                      o_rline0,
    output line_t                      o_rline1
);
    line_t bank [2][SETS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (i_we[w][b]) bank[w][i_index].b[b] <= i_wline.b[b];
            end
        end
        o_rline0 <= bank[0][i_index];   // old data on a same-edge write
        o_rline1 <= bank[1][i_index];
    end

endmodule

//--- rtl/access_fmt.sv
`timescale 1ns/1ps

module access_fmt import dcache_pkg::*; (
    input  logic [31:0]           i_addr,
    input  logic [31:0]           i_wdata,
    input  logic [3:0]            i_wstrb,
    input  logic                  i_signed,
    input  logic                  i_store,
    input  logic                  i_wsel,       // merge base: 1 fill line, 0 hit line
    input  line_t                 i_hit_line,
    input  line_t                 i_fill_line,
    output line_t                 o_store_line,
    output logic [LINE_BYTES-1:0] o_store_be,
    output logic [31:0]           o_rdata,
    output logic                  o_ale
);
    logic [31:0] wshift;
    logic [3:0]  bsh;
    line_t       base;
    logic [31:0] word;
    logic [15:0] half;
    logic [7:0]  bval;

    // store data and mask moved to their byte lanes
    assign wshift = i_wdata << {i_addr[1:0], 3'b000};
    assign bsh    = i_wstrb << i_addr[1:0];
    assign base   = i_wsel ? i_fill_line : i_hit_line;

    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            o_store_be[b]     = i_store && (b / 4 == i_addr[OFFSET_W-1:2]) && bsh[b % 4];
            o_store_line.b[b] = o_store_be[b] ? wshift[8 * (b % 4) +: 8] : base.b[b];
        end
    end

    // load path
    assign word = i_hit_line.w[i_addr[OFFSET_W-1:2]];
    assign half = i_addr[1] ? word[31:16] : word[15:0];
    assign bval = word[{i_addr[1:0], 3'b000} +: 8];

    always_comb begin
        case (i_wstrb)
            STRB_BYTE: o_rdata = {{24{i_signed & bval[7]}}, bval};
            STRB_HALF: o_rdata = {{16{i_signed & half[15]}}, half};
            default:   o_rdata = word;
        endcase
    end

    assign o_ale = ((i_wstrb == STRB_HALF) && i_addr[0])
                || ((i_wstrb == STRB_WORD) && (i_addr[1:0] != 2'b00));

endmodule

//--- rtl/wb_engine.sv
`timescale 1ns/1ps

module wb_engine import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    wr_if.slave               wr,
    output logic              o_mem_wvalid,
    input  logic              i_mem_wready,
    output logic [31:0]       o_mem_waddr,
    output logic [LINE_W-1:0] o_mem_wdata
);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_mem_wvalid <= 1'b0;
            wr.done      <= 1'b0;
        end else if (wr.start) begin
            o_mem_wvalid <= 1'b1;
            wr.done      <= 1'b0;
        end else if (o_mem_wvalid && i_mem_wready) begin
            o_mem_wvalid <= 1'b0;
            wr.done      <= 1'b1;   // stays up until the next start
        end
    end

    // victim line and address, held through back-pressure
    always_ff @(posedge clk) begin
        if (wr.start) begin
            o_mem_waddr <= wr.addr;
            o_mem_wdata <= wr.line;
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (!rstn)
        wr.start |-> !o_mem_wvalid)
        else $error("writeback started while a write is pending");

endmodule

//--- rtl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    // pipeline side
    input  logic [31:0]       i_addr,
    input  logic              i_rvalid,
    input  logic              i_wvalid,
    input  logic [31:0]       i_wdata,
    input  logic [3:0]        i_wstrb,
    input  logic              i_signed,
    output logic              o_rready,
    output logic              o_wready,
    output logic [31:0]       o_rdata,
    output logic              o_idle,
    output logic [6:0]        o_exception,
    output logic [31:0]       o_badv,
    // memory read channel
    output logic              o_mem_rvalid,
    input  logic              i_mem_rready,
    output logic [31:0]       o_mem_raddr,
    input  logic [LINE_W-1:0] i_mem_rdata,
    // memory write channel
    output logic              o_mem_wvalid,
    input  logic              i_mem_wready,
    output logic [31:0]       o_mem_waddr,
    output logic [LINE_W-1:0] o_mem_wdata
);
    logic [INDEX_W-1:0]          data_index;
    logic [1:0][LINE_BYTES-1:0]  data_we;
    logic                        data_wsel;
    line_t                       rline0;
    line_t                       rline1;
    line_t                       sel_line;
    line_t                       store_line;
    logic [LINE_BYTES-1:0]       store_be;
    logic                        ale;
    logic [31:0]                 req_addr;
    logic [31:0]                 req_wdata;
    logic [3:0]                  req_wstrb;
    logic                        req_signed;
    logic                        req_store;

    meta_if meta ();
    wr_if   wr ();

    cache_ctrl u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .i_addr       (i_addr),
        .i_rvalid     (i_rvalid),
        .i_wvalid     (i_wvalid),
        .i_wdata      (i_wdata),
        .i_wstrb      (i_wstrb),
        .i_signed     (i_signed),
        .meta         (meta.master),
        .wr           (wr.master),
        .o_rready     (o_rready),
        .o_wready     (o_wready),
        .o_idle       (o_idle),
        .o_exception  (o_exception),
        .o_badv       (o_badv),
        .o_mem_rvalid (o_mem_rvalid),
        .i_mem_rready (i_mem_rready),
        .o_mem_raddr  (o_mem_raddr),
        .i_mem_wvalid (o_mem_wvalid),
        .i_ale        (ale),
        .i_rline0     (rline0),
        .i_rline1     (rline1),
        .i_store_be   (store_be),
        .o_sel_line   (sel_line),
        .o_data_index (data_index),
        .o_data_we    (data_we),
        .o_data_wsel  (data_wsel),
        .o_req_addr   (req_addr),
        .o_req_wdata  (req_wdata),
        .o_req_wstrb  (req_wstrb),
        .o_req_signed (req_signed),
        .o_req_store  (req_store)
    );

    meta_store u_meta (
        .clk  (clk),
        .rstn (rstn),
        .meta (meta.slave)
    );

    data_store u_data (
        .clk      (clk),
        .i_index  (data_index),
        .i_we     (data_we),
        .i_wline  (store_line),
        .o_rline0 (rline0),
        .o_rline1 (rline1)
    );

    access_fmt u_fmt (
        .i_addr       (req_addr),
        .i_wdata      (req_wdata),
        .i_wstrb      (req_wstrb),
        .i_signed     (req_signed),
        .i_store      (req_store),
        .i_wsel       (data_wsel),
        .i_hit_line   (sel_line),
        .i_fill_line  (i_mem_rdata),
        .o_store_line (store_line),
        .o_store_be   (store_be),
        .o_rdata      (o_rdata),
        .o_ale        (ale)
    );

    wb_engine u_wb (
        .clk          (clk),
        .rstn         (rstn),
        .wr           (wr.slave),
        .o_mem_wvalid (o_mem_wvalid),
        .i_mem_wready (i_mem_wready),
        .o_mem_waddr  (o_mem_waddr),
        .o_mem_wdata  (o_mem_wdata)
    );

endmodule

//--- sim/mem_model.sv
`timescale 1ns/1ps

module mem_model import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              i_rvalid,
    output logic              o_rready,
    input  logic [31:0]       i_raddr,
    output logic [LINE_W-1:0] o_rdata,
    input  logic              i_wvalid,
    output logic              o_wready,
    input  logic [31:0]       i_waddr,
    input  logic [LINE_W-1:0] i_wdata
);
    logic [LINE_W-1:0] lines [logic [31:0]];   // written lines by line address
    logic              rv_s;
    logic              wv_s;
    logic [31:0]       ra_s;
    logic [31:0]       wa_s;
    logic [LINE_W-1:0] wd_s;
    int                rwait;
    int                wwait;
    int                seq;                    // handshake counter, orders reads and writes
    int                n_writes;
    int                last_wseq;
    int                last_rseq;
    logic [31:0]       last_waddr;
    logic [31:0]       last_raddr;

    // fill pattern of untouched memory, mixes every address bit
    function automatic logic [7:0] pat_byte(input logic [31:0] a);
        return {a[1:0], a[7:2]} ^ a[15:8] ^ a[23:16] ^ a[31:24];
    endfunction

    function automatic logic [LINE_W-1:0] line_at(input logic [31:0] la);
        logic [LINE_W-1:0] l;
        if (lines.exists(la)) return lines[la];
        for (int b = 0; b < LINE_BYTES; b++) l[8*b +: 8] = pat_byte(la + 32'(b));
        return l;
    endfunction

    initial begin
        o_rready = 1'b0;
        o_wready = 1'b0;
        o_rdata  = '0;
    end

    // channel state taken mid cycle where it is stable
    always @(negedge clk) begin
        rv_s = i_rvalid;
        wv_s = i_wvalid;
        ra_s = i_raddr;
        wa_s = i_waddr;
        wd_s = i_wdata;
    end

    always @(posedge clk) begin
        #1;
        if (!rstn) begin
            o_rready   = 1'b0;
            o_wready   = 1'b0;
            rwait      = $urandom_range(0, 3);
            wwait      = $urandom_range(0, 3);
            seq        = 0;
            n_writes   = 0;
            last_wseq  = 0;
            last_rseq  = 0;
            last_waddr = '0;
            last_raddr = '0;
        end else begin
            if (o_wready && wv_s) begin      // write accepted on this edge
                lines[wa_s] = wd_s;
                seq++;
                n_writes++;
                last_wseq  = seq;
                last_waddr = wa_s;
                o_wready   = 1'b0;
                wwait      = $urandom_range(0, 3);
            end else if (i_wvalid) begin
                if (wwait == 0) o_wready = 1'b1;
                else wwait--;
            end
            if (o_rready && rv_s) begin
                seq++;
                last_rseq  = seq;
                last_raddr = ra_s;
                o_rready   = 1'b0;
                rwait      = $urandom_range(0, 3);
            end else if (i_rvalid) begin
                if (rwait == 0) begin
                    o_rready = 1'b1;
                    o_rdata  = line_at(i_raddr);   // data rides with ready
                end else begin
                    rwait--;
                end
            end
        end
    end

endmodule

//--- sim/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();
    localparam int               TIMEOUT = 400;   // cycles per wait
    localparam logic [TAG_W-1:0] TAGS [3] = '{20'h00010, 20'h00a37, 20'h3c001};

    logic              clk;
    logic              rstn;
    logic [31:0]       i_addr;
    logic              i_rvalid;
    logic              i_wvalid;
    logic [31:0]       i_wdata;
    logic [3:0]        i_wstrb;
    logic              i_signed;
    logic              o_rready;
    logic              o_wready;
    logic [31:0]       o_rdata;
    logic              o_idle;
    logic [6:0]        o_exception;
    logic [31:0]       o_badv;
    logic              o_mem_rvalid;
    logic              i_mem_rready;
    logic [31:0]       o_mem_raddr;
    logic [LINE_W-1:0] i_mem_rdata;
    logic              o_mem_wvalid;
    logic              i_mem_wready;
    logic [31:0]       o_mem_waddr;
    logic [LINE_W-1:0] o_mem_wdata;

    logic [7:0]        ref_mem [logic [31:0]];   // bytes stored so far
    logic [31:0]       exp_rdata;
    logic [6:0]        exp_exc;
    logic [31:0]       exp_badv;
    logic              exp_fast;                 // response due in the lookup cycle
    logic              cur_store;

    dcache_top uut (.*);

    mem_model u_mem (
        .clk      (clk),
        .rstn     (rstn),
        .i_rvalid (o_mem_rvalid),
        .o_rready (i_mem_rready),
        .i_raddr  (o_mem_raddr),
        .o_rdata  (i_mem_rdata),
        .i_wvalid (o_mem_wvalid),
        .o_wready (i_mem_wready),
        .i_waddr  (o_mem_waddr),
        .i_wdata  (o_mem_wdata)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // same fill pattern as the backing memory
    function automatic logic [7:0] pat_byte(input logic [31:0] a);
        return {a[1:0], a[7:2]} ^ a[15:8] ^ a[23:16] ^ a[31:24];
    endfunction

    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        if (ref_mem.exists(a)) return ref_mem[a];
        return pat_byte(a);
    endfunction

    function automatic logic [LINE_W-1:0] ref_line(input logic [31:0] la);
        logic [LINE_W-1:0] l;
        for (int b = 0; b < LINE_BYTES; b++) l[8*b +: 8] = ref_byte(la + 32'(b));
        return l;
    endfunction

    function automatic logic misaligned(input logic [31:0] a, input logic [3:0] strb);
        return (strb == STRB_HALF && a[0]) || (strb == STRB_WORD && a[1:0] != 2'b00);
    endfunction

    // little endian read and extension by size
    function automatic logic [31:0] load_value(input logic [31:0] a, input logic [3:0] strb,
                                               input logic sgn);
        logic [31:0] v;
        v = {ref_byte(a + 3), ref_byte(a + 2), ref_byte(a + 1), ref_byte(a)};
        case (strb)
            STRB_BYTE: return {{24{sgn & v[7]}}, v[7:0]};
            STRB_HALF: return {{16{sgn & v[15]}}, v[15:0]};
            default:   return v;
        endcase
    endfunction

    task automatic access(input logic [31:0] a, input logic st, input logic [3:0] strb,
                          input logic sgn, input logic [31:0] wd, input logic fast);
        int   n;
        logic bad;
        bad       = misaligned(a, strb);
        exp_exc   = bad ? EXP_ALE : 7'd0;
        exp_badv  = a;
        exp_rdata = load_value(a, strb, sgn);
        exp_fast  = fast || bad;
        cur_store = st;
        if (st && !bad) begin
            for (int k = 0; k < 4; k++) begin
                if (strb[k]) ref_mem[a + 32'(k)] = wd[8*k +: 8];
            end
        end
        n = 0;
        while (!o_idle) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for the cache to go idle");
        end
        i_addr   = a;
        i_wdata  = wd;
        i_wstrb  = strb;
        i_signed = sgn;
        i_rvalid = !st;
        i_wvalid = st;
        @(posedge clk);
        #1;
        i_rvalid = 1'b0;
        i_wvalid = 1'b0;
        n = 0;
        while (!(o_rready || o_wready)) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for a response pulse");
        end
        @(posedge clk);
        #1;
    endtask

    a_load_data: assert property (@(posedge clk) disable iff (!rstn)
        (o_rready && exp_exc == 7'd0) |-> (o_rdata == exp_rdata))
        else abort_run($sformatf("ERR o_rdata exp=%h got=%h", exp_rdata, $sampled(o_rdata)));

    a_resp_kind: assert property (@(posedge clk) disable iff (!rstn)
        (o_rready || o_wready) |-> (o_wready == cur_store && o_rready == !cur_store))
        else abort_run("response pulse does not match the request type");

    a_exception: assert property (@(posedge clk) disable iff (!rstn)
        (o_rready || o_wready) |-> (o_exception == exp_exc))
        else abort_run($sformatf("ERR o_exception exp=%h got=%h", exp_exc,
                                 $sampled(o_exception)));

    a_badv: assert property (@(posedge clk) disable iff (!rstn)
        ((o_rready || o_wready) && exp_exc != 7'd0) |-> (o_badv == exp_badv))
        else abort_run($sformatf("ERR o_badv exp=%h got=%h", exp_badv, $sampled(o_badv)));

    a_hit_time: assert property (@(posedge clk) disable iff (!rstn)
        (o_idle && (i_rvalid || i_wvalid) && exp_fast) |=> (o_rready || o_wready))
        else abort_run("response did not come one cycle after acceptance");

    a_no_mem_ale: assert property (@(posedge clk) disable iff (!rstn)
        (!o_idle && exp_exc != 7'd0) |-> !(o_mem_rvalid || o_mem_wvalid))
        else abort_run("memory request raised for a misaligned access");

    // a writeback carries the reference contents of its line
    always @(negedge clk) begin
        if (rstn && o_mem_wvalid && i_mem_wready) begin
            assert (o_mem_wdata == ref_line(o_mem_waddr))
                else abort_run($sformatf("ERR o_mem_wdata addr=%h exp=%h got=%h",
                                         o_mem_waddr, ref_line(o_mem_waddr), o_mem_wdata));
        end
    end

    initial begin
        logic [31:0] base;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] z;
        logic [31:0] addr;
        logic [3:0]  strb;
        int          nw;
        void'($urandom(42));
        clk       = 1'b0;
        rstn      = 1'b0;
        i_addr    = '0;
        i_rvalid  = 1'b0;
        i_wvalid  = 1'b0;
        i_wdata   = '0;
        i_wstrb   = STRB_WORD;
        i_signed  = 1'b0;
        exp_rdata = '0;
        exp_exc   = '0;
        exp_badv  = '0;
        exp_fast  = 1'b0;
        cur_store = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        assert (o_idle && !o_rready && !o_wready && !o_mem_rvalid && !o_mem_wvalid
                && o_exception == 7'd0)
            else abort_run("control outputs active after reset");

        base = 32'h0001_0200;   // set 8
        access(base + 4, 1'b0, STRB_WORD, 1'b0, 32'd0, 1'b0);
        access(base + 4, 1'b0, STRB_WORD, 1'b0, 32'd0, 1'b1);
        for (int off = 0; off < 4; off++) begin
            access(base + 8 + 32'(off), 1'b0, STRB_BYTE, 1'b0, 32'd0, 1'b1);
            access(base + 8 + 32'(off), 1'b0, STRB_BYTE, 1'b1, 32'd0, 1'b1);
        end
        for (int off = 0; off < 4; off += 2) begin
            access(base + 12 + 32'(off), 1'b0, STRB_HALF, 1'b0, 32'd0, 1'b1);
            access(base + 12 + 32'(off), 1'b0, STRB_HALF, 1'b1, 32'd0, 1'b1);
        end

        // store then load in set 9
        access(base + 32'h41, 1'b1, STRB_BYTE, 1'b0, $urandom, 1'b0);
        access(base + 32'h40, 1'b0, STRB_WORD, 1'b0, 32'd0, 1'b1);
        access(base + 32'h46, 1'b1, STRB_HALF, 1'b0, $urandom, 1'b1);
        access(base + 32'h44, 1'b0, STRB_WORD, 1'b0, 32'd0, 1'b1);
        access(base + 32'h46, 1'b0, STRB_HALF, 1'b1, 32'd0, 1'b1);
        access(base + 32'h48, 1'b1, STRB_WORD, 1'b0, $urandom, 1'b1);
        access(base + 32'h48, 1'b0, STRB_WORD, 1'b0, 32'd0, 1'b1);
        access(base + 32'h41, 1'b0, STRB_BYTE, 1'b1, 32'd0, 1'b1);

        // three tags in set 63 with the first line as the dirty victim
        x = {TAGS[0], 6'd63, 6'd0};
        y = {TAGS[1], 6'd63, 6'd8};
        z = {TAGS[2], 6'd63, 6'd20};
        access(x, 1'b1, STRB_WORD, 1'b0, $urandom, 1'b0);
        access(y, 1'b1, STRB_WORD, 1'b0, $urandom, 1'b0);
        nw = u_mem.n_writes;
        access(z, 1'b1, STRB_HALF, 1'b0, $urandom, 1'b0);
        assert (u_mem.n_writes == nw + 1) else abort_run("eviction did not write back one line");
        assert (u_mem.last_waddr == x)
            else abort_run($sformatf("ERR o_mem_waddr exp=%h got=%h", x, u_mem.last_waddr));
        assert (u_mem.last_raddr == {z[31:OFFSET_W], 6'd0})
            else abort_run($sformatf("ERR o_mem_raddr exp=%h got=%h",
                                     {z[31:OFFSET_W], 6'd0}, u_mem.last_raddr));
        assert (u_mem.last_wseq < u_mem.last_rseq)
            else abort_run("victim writeback came after the refill read");
        access(x, 1'b0, STRB_WORD, 1'b0, 32'd0, 1'b0);

        // misaligned loads and stores
        access(base + 1, 1'b0, STRB_HALF, 1'b0, 32'd0, 1'b1);
        access(base + 6, 1'b0, STRB_WORD, 1'b1, 32'd0, 1'b1);
        access(base + 3, 1'b1, STRB_HALF, 1'b0, $urandom, 1'b1);
        access(base + 9, 1'b1, STRB_WORD, 1'b0, $urandom, 1'b1);

        // random traffic over four sets with three tags each
        for (int k = 0; k < 80; k++) begin
            case ($urandom_range(0, 2))
                0:       strb = STRB_BYTE;
                1:       strb = STRB_HALF;
                default: strb = STRB_WORD;
            endcase
            addr = {TAGS[$urandom_range(0, 2)], 6'($urandom_range(0, 3)),
                    6'($urandom_range(0, 63))};
            if (strb == STRB_HALF) addr[0] = 1'b0;
            if (strb == STRB_WORD) addr[1:0] = 2'b00;
            access(addr, 1'($urandom_range(0, 1)), strb, 1'($urandom_range(0, 1)),
                   $urandom, 1'b0);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

//--- files.f
rtl/dcache_pkg.sv
rtl/dcache_ifs.sv
rtl/cache_ctrl.sv
rtl/meta_store.sv
rtl/data_store.sv
rtl/access_fmt.sv
rtl/wb_engine.sv
rtl/dcache_top.sv
sim/mem_model.sv
sim/tb_dcache.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f files.f \
    -o sim_dcache \
    && ./obj_dir/sim_dcache | tee sim.log
grep -q "All tests passed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
